//--- design/fetch_pkg.sv
package fetch_pkg;

    // queue geometry
    localparam int fifo_depth = 16;
    localparam int ptr_width = 4;
    // one bit wider than the pointer so 16 entries can be counted
    localparam int count_width = 5;

    // instruction side
    localparam int addr_width = 32;
    // exception bits carried with each word
    localparam int exp_width = 12;

    // full at 12 leaves four free slots
    // a pair already in flight always lands
    localparam logic [count_width-1:0] full_level = 5'd12;

    // boot vector
    localparam logic [addr_width-1:0] reset_pc = 32'hbfc0_0000;

endpackage

//--- design/mips_inst_pkg.sv
package mips_inst_pkg;

    // one 32-bit word, seen as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r_view;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i_view;
    } inst_word_t;

    // opcodes used by the pairing logic
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm = 6'h01;
    localparam logic [5:0] op_j = 6'h02;
    localparam logic [5:0] op_jal = 6'h03;
    localparam logic [5:0] op_beq = 6'h04;
    localparam logic [5:0] op_bne = 6'h05;
    localparam logic [5:0] op_blez = 6'h06;
    localparam logic [5:0] op_bgtz = 6'h07;

    // funct codes under op_special
    localparam logic [5:0] fn_jr = 6'h08;
    localparam logic [5:0] fn_jalr = 6'h09;

    // addi .. lui, result goes to rt
    localparam logic [5:0] op_alu_imm_lo = 6'h08;
    localparam logic [5:0] op_alu_imm_hi = 6'h0f;
    // lb .. lwr, result goes to rt
    localparam logic [5:0] op_load_lo = 6'h20;
    localparam logic [5:0] op_load_hi = 6'h27;

endpackage

//--- design/fetch_pc_gen.sv
`timescale 1ns/100ps

module fetch_pc_gen (
    input  logic                             clk,
    input  logic                             fifo_rst,
    input  logic                             full,
    input  logic                             redirect,
    input  logic [fetch_pkg::addr_width-1:0] redirect_pc,
    output logic                             imem_req,
    output logic [fetch_pkg::addr_width-1:0] imem_addr,
    output logic [fetch_pkg::addr_width-1:0] write_address1,
    output logic [fetch_pkg::addr_width-1:0] write_address2
);

    // next pair to ask for
    logic [fetch_pkg::addr_width-1:0] pc;
    // address of the pair the memory answers this cycle
    logic [fetch_pkg::addr_width-1:0] inflight_addr;
    // low for the first cycle out of reset
    logic run;

    // no request while the queue is near full or a redirect is pending
    assign imem_req = run & ~full & ~redirect;
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            run <= 1'b0;
            pc <= fetch_pkg::reset_pc;
        end else begin
            run <= 1'b1;
            // redirect beats the sequential step
            if (redirect) begin
                pc <= redirect_pc;
            end else if (imem_req) begin
                // pairs are 8-byte aligned
                pc <= pc + 32'd8;
            end
        end
    end

    // remember what was asked, memory answers one cycle later
    always_ff @(posedge clk) begin
        if (imem_req) begin
            inflight_addr <= pc;
        end
    end

    // second word of the pair sits one word up
    assign write_address1 = inflight_addr;
    assign write_address2 = inflight_addr + 32'd4;

endmodule

//--- design/inst_fifo.sv
`timescale 1ns/100ps

module inst_fifo (
    input  logic                             clk,
    input  logic                             fifo_rst,
    input  logic                             redirect,
    input  logic                             master_is_branch,
    input  logic                             read_en1,
    input  logic                             read_en2,
    input  logic                             write_en1,
    input  logic                             write_en2,
    input  logic [31:0]                      write_data1,
    input  logic [31:0]                      write_data2,
    input  logic [fetch_pkg::addr_width-1:0] write_address1,
    input  logic [fetch_pkg::addr_width-1:0] write_address2,
    input  logic [fetch_pkg::exp_width-1:0]  write_inst_exp1,
    input  logic [fetch_pkg::exp_width-1:0]  write_inst_exp2,
    output logic [31:0]                      read_data1,
    output logic [31:0]                      read_data2,
    output logic [fetch_pkg::addr_width-1:0] read_addres1,
    output logic [fetch_pkg::addr_width-1:0] read_addres2,
    output logic [fetch_pkg::exp_width-1:0]  inst_exp1,
    output logic [fetch_pkg::exp_width-1:0]  inst_exp2,
    output logic                             master_is_in_delayslot_o,
    output logic                             empty,
    output logic                             almost_empty,
    output logic                             full
);

    // entry storage, indexed by the pointers
    logic [31:0]                      data_mem [fetch_pkg::fifo_depth];
    logic [fetch_pkg::addr_width-1:0] addr_mem [fetch_pkg::fifo_depth];
    logic [fetch_pkg::exp_width-1:0]  exp_mem  [fetch_pkg::fifo_depth];

    logic [fetch_pkg::ptr_width-1:0]   wr_ptr;
    logic [fetch_pkg::ptr_width-1:0]   rd_ptr;
    logic [fetch_pkg::ptr_width-1:0]   wr_ptr_inc;
    logic [fetch_pkg::ptr_width-1:0]   rd_ptr_inc;
    logic [fetch_pkg::count_width-1:0] count;

    // accepted writes and reads this cycle
    logic       wr1;
    logic       wr2;
    logic       rd1;
    logic       rd2;
    // 0, 1 or 2 entries moved
    logic [1:0] wr_cnt;
    logic [1:0] rd_cnt;
    logic       flush;

    // a redirect empties the queue by pointer reset only
    assign flush = fifo_rst | redirect;

    // slot 2 only ever follows slot 1
    assign wr1 = write_en1;
    assign wr2 = write_en1 & write_en2;
    // reads past the held entries are ignored
    assign rd1 = read_en1 & ~empty;
    assign rd2 = rd1 & read_en2 & ~almost_empty;

    assign wr_cnt = {wr2, wr1 & ~wr2};
    assign rd_cnt = {rd2, rd1 & ~rd2};

    // neighbour entries, wrap with the pointer width
    assign wr_ptr_inc = wr_ptr + {{(fetch_pkg::ptr_width-1){1'b0}}, 1'b1};
    assign rd_ptr_inc = rd_ptr + {{(fetch_pkg::ptr_width-1){1'b0}}, 1'b1};

    // status from the count
    assign empty = (count == '0);
    assign almost_empty = (count == {{(fetch_pkg::count_width-1){1'b0}}, 1'b1});
    assign full = (count >= fetch_pkg::full_level);

    // pointers and count, flush wins over a write in the same cycle
    always_ff @(posedge clk) begin
        if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            wr_ptr <= wr_ptr + {{(fetch_pkg::ptr_width-2){1'b0}}, wr_cnt};
            rd_ptr <= rd_ptr + {{(fetch_pkg::ptr_width-2){1'b0}}, rd_cnt};
            count <= count + {{(fetch_pkg::count_width-2){1'b0}}, wr_cnt}
                           - {{(fetch_pkg::count_width-2){1'b0}}, rd_cnt};
        end
    end

    // write both words of a pair with their own address and exception bits
    always_ff @(posedge clk) begin
        if (wr1) begin
            data_mem[wr_ptr] <= write_data1;
            addr_mem[wr_ptr] <= write_address1;
            exp_mem[wr_ptr] <= write_inst_exp1;
        end
        if (wr2) begin
            data_mem[wr_ptr_inc] <= write_data2;
            addr_mem[wr_ptr_inc] <= write_address2;
            exp_mem[wr_ptr_inc] <= write_inst_exp2;
        end
    end

    // head of queue, zero where no entry is held
    always_comb begin
        read_data1 = '0;
        read_data2 = '0;
        read_addres1 = '0;
        read_addres2 = '0;
        inst_exp1 = '0;
        inst_exp2 = '0;
        if (!empty) begin
            read_data1 = data_mem[rd_ptr];
            read_addres1 = addr_mem[rd_ptr];
            inst_exp1 = exp_mem[rd_ptr];
        end
        // second slot needs two entries
        if (!empty && !almost_empty) begin
            read_data2 = data_mem[rd_ptr_inc];
            read_addres2 = addr_mem[rd_ptr_inc];
            inst_exp2 = exp_mem[rd_ptr_inc];
        end
    end

    // branch left the queue alone, so the next head is its delay slot
    // held through stalls until that head is read
    always_ff @(posedge clk) begin
        if (flush) begin
            master_is_in_delayslot_o <= 1'b0;
        end else if (rd1) begin
            master_is_in_delayslot_o <= master_is_branch & ~rd2;
        end
    end

endmodule

//--- design/dual_issue_ctrl.sv
`timescale 1ns/100ps

module dual_issue_ctrl (
    input  logic                             decode_stall,
    input  logic                             empty,
    input  logic                             almost_empty,
    input  logic [31:0]                      read_data1,
    input  logic [31:0]                      read_data2,
    input  logic [fetch_pkg::addr_width-1:0] read_addres1,
    input  logic [fetch_pkg::addr_width-1:0] read_addres2,
    input  logic [fetch_pkg::exp_width-1:0]  inst_exp1,
    input  logic [fetch_pkg::exp_width-1:0]  inst_exp2,
    input  logic                             master_is_in_delayslot_o,
    output logic                             read_en1,
    output logic                             read_en2,
    output logic                             master_is_branch,
    output logic                             issue_valid1,
    output logic                             issue_valid2,
    output logic [31:0]                      issue_inst1,
    output logic [31:0]                      issue_inst2,
    output logic [fetch_pkg::addr_width-1:0] issue_pc1,
    output logic [fetch_pkg::addr_width-1:0] issue_pc2,
    output logic [fetch_pkg::exp_width-1:0]  issue_exp1,
    output logic [fetch_pkg::exp_width-1:0]  issue_exp2,
    output logic                             issue_delay_slot
);

    // branches and jumps, register jumps live under op_special
    function automatic logic is_branch(input mips_inst_pkg::inst_word_t w);
        logic [5:0] op;
        op = w.r_view.op;
        is_branch = (op == mips_inst_pkg::op_beq) || (op == mips_inst_pkg::op_bne) ||
                    (op == mips_inst_pkg::op_blez) || (op == mips_inst_pkg::op_bgtz) ||
                    (op == mips_inst_pkg::op_regimm) || (op == mips_inst_pkg::op_j) ||
                    (op == mips_inst_pkg::op_jal) ||
                    ((op == mips_inst_pkg::op_special) &&
                     ((w.r_view.funct == mips_inst_pkg::fn_jr) ||
                      (w.r_view.funct == mips_inst_pkg::fn_jalr)));
    endfunction

    // register written by the word, 0 for none
    function automatic logic [4:0] dest_reg(input mips_inst_pkg::inst_word_t w);
        logic [5:0] op;
        op = w.r_view.op;
        dest_reg = 5'd0;
        if (op == mips_inst_pkg::op_special) begin
            dest_reg = w.r_view.rd;
        end else if ((op >= mips_inst_pkg::op_alu_imm_lo && op <= mips_inst_pkg::op_alu_imm_hi) ||
                     (op >= mips_inst_pkg::op_load_lo && op <= mips_inst_pkg::op_load_hi)) begin
            dest_reg = w.i_view.rt;
        end else if (op == mips_inst_pkg::op_jal) begin
            // link register
            dest_reg = 5'd31;
        end
    endfunction

    mips_inst_pkg::inst_word_t inst1;
    mips_inst_pkg::inst_word_t inst2;
    logic [4:0] dest1;
    logic       hazard;
    logic       issue1;
    logic       issue2;

    assign inst1 = read_data1;
    assign inst2 = read_data2;
    assign dest1 = dest_reg(inst1);

    // rs and rt compared as raw fields, conservative for I-type
    assign hazard = (dest1 != 5'd0) &&
                    ((inst2.i_view.rs == dest1) || (inst2.i_view.rt == dest1));

    // master slot goes whenever decode can take it
    assign issue1 = ~empty & ~decode_stall;
    // slave slot needs a second entry, no branch and no RAW on slot 1
    assign issue2 = issue1 & ~almost_empty & ~is_branch(inst2) & ~hazard;

    assign read_en1 = issue1;
    assign read_en2 = issue2;
    assign master_is_branch = ~empty & is_branch(inst1);

    assign issue_valid1 = issue1;
    assign issue_valid2 = issue2;
    assign issue_inst1 = read_data1;
    assign issue_inst2 = read_data2;
    assign issue_pc1 = read_addres1;
    assign issue_pc2 = read_addres2;
    assign issue_exp1 = inst_exp1;
    assign issue_exp2 = inst_exp2;
    // marker only shows while the delay slot actually issues
    assign issue_delay_slot = master_is_in_delayslot_o & issue1;

endmodule

//--- design/fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
    input  logic                             clk,
    input  logic                             fifo_rst,
    input  logic                             redirect,
    input  logic [fetch_pkg::addr_width-1:0] redirect_pc,
    input  logic                             decode_stall,
    input  logic                             imem_ok,
    input  logic [31:0]                      imem_data1,
    input  logic [31:0]                      imem_data2,
    input  logic [fetch_pkg::exp_width-1:0]  imem_exp1,
    input  logic [fetch_pkg::exp_width-1:0]  imem_exp2,
    output logic                             imem_req,
    output logic [fetch_pkg::addr_width-1:0] imem_addr,
    output logic                             issue_valid1,
    output logic                             issue_valid2,
    output logic [31:0]                      issue_inst1,
    output logic [31:0]                      issue_inst2,
    output logic [fetch_pkg::addr_width-1:0] issue_pc1,
    output logic [fetch_pkg::addr_width-1:0] issue_pc2,
    output logic [fetch_pkg::exp_width-1:0]  issue_exp1,
    output logic [fetch_pkg::exp_width-1:0]  issue_exp2,
    output logic                             issue_delay_slot,
    output logic                             empty,
    output logic                             full
);

    // fetch to queue
    logic [fetch_pkg::addr_width-1:0] write_address1;
    logic [fetch_pkg::addr_width-1:0] write_address2;

    // queue head to issue
    logic [31:0]                      read_data1;
    logic [31:0]                      read_data2;
    logic [fetch_pkg::addr_width-1:0] read_addres1;
    logic [fetch_pkg::addr_width-1:0] read_addres2;
    logic [fetch_pkg::exp_width-1:0]  inst_exp1;
    logic [fetch_pkg::exp_width-1:0]  inst_exp2;
    logic                             almost_empty;
    logic                             master_is_in_delayslot_o;

    // issue back to queue
    logic read_en1;
    logic read_en2;
    logic master_is_branch;

    fetch_pc_gen pc_gen_i (
        .clk            (clk),
        .fifo_rst       (fifo_rst),
        .full           (full),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .imem_req       (imem_req),
        .imem_addr      (imem_addr),
        .write_address1 (write_address1),
        .write_address2 (write_address2)
    );

    // memory always answers with a full pair
    inst_fifo fifo_i (
        .clk                      (clk),
        .fifo_rst                 (fifo_rst),
        .redirect                 (redirect),
        .master_is_branch         (master_is_branch),
        .read_en1                 (read_en1),
        .read_en2                 (read_en2),
        .write_en1                (imem_ok),
        .write_en2                (imem_ok),
        .write_data1              (imem_data1),
        .write_data2              (imem_data2),
        .write_address1           (write_address1),
        .write_address2           (write_address2),
        .write_inst_exp1          (imem_exp1),
        .write_inst_exp2          (imem_exp2),
        .read_data1               (read_data1),
        .read_data2               (read_data2),
        .read_addres1             (read_addres1),
        .read_addres2             (read_addres2),
        .inst_exp1                (inst_exp1),
        .inst_exp2                (inst_exp2),
        .master_is_in_delayslot_o (master_is_in_delayslot_o),
        .empty                    (empty),
        .almost_empty             (almost_empty),
        .full                     (full)
    );

    dual_issue_ctrl issue_i (
        .decode_stall             (decode_stall),
        .empty                    (empty),
        .almost_empty             (almost_empty),
        .read_data1               (read_data1),
        .read_data2               (read_data2),
        .read_addres1             (read_addres1),
        .read_addres2             (read_addres2),
        .inst_exp1                (inst_exp1),
        .inst_exp2                (inst_exp2),
        .master_is_in_delayslot_o (master_is_in_delayslot_o),
        .read_en1                 (read_en1),
        .read_en2                 (read_en2),
        .master_is_branch         (master_is_branch),
        .issue_valid1             (issue_valid1),
        .issue_valid2             (issue_valid2),
        .issue_inst1              (issue_inst1),
        .issue_inst2              (issue_inst2),
        .issue_pc1                (issue_pc1),
        .issue_pc2                (issue_pc2),
        .issue_exp1               (issue_exp1),
        .issue_exp2               (issue_exp2),
        .issue_delay_slot         (issue_delay_slot)
    );

endmodule

//--- test/fetch_assertions.sv
`timescale 1ns/100ps

module fetch_assertions (
    input logic clk,
    input logic fifo_rst,
    input logic empty,
    input logic full,
    input logic almost_empty,
    input logic master_is_in_delayslot_o
);

    // count cannot be zero and at the full level at once
    assert property (@(posedge clk) disable iff (fifo_rst) !(empty && full))
        else $error("queue reports empty and full together");

    // one entry held means not empty
    assert property (@(posedge clk) disable iff (fifo_rst) almost_empty |-> !empty)
        else $error("almost_empty raised on an empty queue");

    // delay-slot marker comes out of reset cleared
    assert property (@(posedge clk) $fell(fifo_rst) |-> !master_is_in_delayslot_o)
        else $error("delay-slot marker set right after reset");

endmodule

//--- test/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;

    localparam int reset_cycles = 10;
    localparam int test_cycles = 3000;
    // first stretch runs with no stall and no redirect
    localparam int calm_cycles = 200;
    localparam int cycle_limit = reset_cycles + test_cycles + 300;
    localparam logic [31:0] lfsr_seed = 32'h4e99_0cb2;

    logic        clk;
    logic        fifo_rst;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        decode_stall;
    logic        imem_ok;
    logic [31:0] imem_data1;
    logic [31:0] imem_data2;
    logic [11:0] imem_exp1;
    logic [11:0] imem_exp2;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        issue_valid1;
    logic        issue_valid2;
    logic [31:0] issue_inst1;
    logic [31:0] issue_inst2;
    logic [31:0] issue_pc1;
    logic [31:0] issue_pc2;
    logic [11:0] issue_exp1;
    logic [11:0] issue_exp2;
    logic        issue_delay_slot;
    logic        empty;
    logic        full;

    logic [31:0] lfsr_state;
    // request seen by memory in the cycle it was made
    logic        req_q = 1'b0;
    logic [31:0] addr_q = '0;
    logic [31:0] expected_pc;
    // next pair address fetch should ask for
    logic [31:0] fetch_pc;
    logic        ds_pending;
    logic [31:0] branch_pc;
    int          issued = 0;
    int          redirects = 0;
    int          delay_slots = 0;
    int          full_seen = 0;
    int          cycles = 0;

    fetch_top dut_i (
        .clk              (clk),
        .fifo_rst         (fifo_rst),
        .redirect         (redirect),
        .redirect_pc      (redirect_pc),
        .decode_stall     (decode_stall),
        .imem_ok          (imem_ok),
        .imem_data1       (imem_data1),
        .imem_data2       (imem_data2),
        .imem_exp1        (imem_exp1),
        .imem_exp2        (imem_exp2),
        .imem_req         (imem_req),
        .imem_addr        (imem_addr),
        .issue_valid1     (issue_valid1),
        .issue_valid2     (issue_valid2),
        .issue_inst1      (issue_inst1),
        .issue_inst2      (issue_inst2),
        .issue_pc1        (issue_pc1),
        .issue_pc2        (issue_pc2),
        .issue_exp1       (issue_exp1),
        .issue_exp2       (issue_exp2),
        .issue_delay_slot (issue_delay_slot),
        .empty            (empty),
        .full             (full)
    );

    bind inst_fifo fetch_assertions asrt_i (
        .clk                      (clk),
        .fifo_rst                 (fifo_rst),
        .empty                    (empty),
        .full                     (full),
        .almost_empty             (almost_empty),
        .master_is_in_delayslot_o (master_is_in_delayslot_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] addr_hash(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        addr_hash = h ^ (h >> 13);
    endfunction

    // half branches, half ALU or load, registers 0..3 only
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] h;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        h = addr_hash(a);
        rs = {3'd0, h[9:8]};
        rt = {3'd0, h[11:10]};
        rd = {3'd0, h[13:12]};
        case (h[2:0])
            3'd0: mem_word = {mips_inst_pkg::op_beq, rs, rt, h[31:16]};
            3'd1: mem_word = {mips_inst_pkg::op_bne, rs, rt, h[31:16]};
            3'd2: mem_word = {mips_inst_pkg::op_special, rs, 15'd0, mips_inst_pkg::fn_jr};
            3'd3: mem_word = {mips_inst_pkg::op_jal, h[31:6]};
            // addiu
            3'd4: mem_word = {6'h09, rs, rt, h[31:16]};
            // lw
            3'd5: mem_word = {6'h23, rs, rt, h[31:16]};
            // addu
            default: mem_word = {mips_inst_pkg::op_special, rs, rt, rd, 5'd0, 6'h21};
        endcase
    endfunction

    function automatic logic [11:0] mem_exp(input logic [31:0] a);
        logic [31:0] h;
        h = addr_hash(a ^ 32'h5a5a_5a5a);
        mem_exp = h[11:0];
    endfunction

    function automatic logic is_branch_word(input logic [31:0] w);
        logic [5:0] op;
        op = w[31:26];
        is_branch_word = op == mips_inst_pkg::op_beq || op == mips_inst_pkg::op_bne ||
                         op == mips_inst_pkg::op_blez || op == mips_inst_pkg::op_bgtz ||
                         op == mips_inst_pkg::op_regimm || op == mips_inst_pkg::op_j ||
                         op == mips_inst_pkg::op_jal ||
                         (op == mips_inst_pkg::op_special &&
                          (w[5:0] == mips_inst_pkg::fn_jr || w[5:0] == mips_inst_pkg::fn_jalr));
    endfunction

    // slot 2 pairs when it is no branch and reads no register slot 1 writes
    function automatic logic pair_ok(input logic [31:0] inst1, input logic [31:0] inst2);
        logic [5:0] op1;
        logic [4:0] dest;
        logic       raw;
        op1 = inst1[31:26];
        dest = 5'd0;
        if (op1 == mips_inst_pkg::op_special) begin
            dest = inst1[15:11];
        end else if ((op1 >= mips_inst_pkg::op_alu_imm_lo && op1 <= mips_inst_pkg::op_alu_imm_hi)
                     || (op1 >= mips_inst_pkg::op_load_lo && op1 <= mips_inst_pkg::op_load_hi)) begin
            dest = inst1[20:16];
        end else if (op1 == mips_inst_pkg::op_jal) begin
            dest = 5'd31;
        end
        raw = dest != 5'd0 && (inst2[25:21] == dest || inst2[20:16] == dest);
        pair_ok = !is_branch_word(inst2) && !raw;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "check %s mismatched", name);
        end
    endtask

    // memory sees the request at the falling edge
    always @(negedge clk) begin
        req_q <= imem_req;
        addr_q <= imem_addr;
    end

    // one-cycle instruction memory, always answers a pair
    initial begin
        imem_ok = 1'b0;
        imem_data1 = '0;
        imem_data2 = '0;
        imem_exp1 = '0;
        imem_exp2 = '0;
        forever begin
            @(posedge clk);
            #2;
            imem_ok = req_q & ~fifo_rst;
            imem_data1 = mem_word(addr_q);
            imem_data2 = mem_word(addr_q + 32'd4);
            imem_exp1 = mem_exp(addr_q);
            imem_exp2 = mem_exp(addr_q + 32'd4);
        end
    end

    // comparator, samples at the falling edge where outputs are settled
    initial begin
        expected_pc = fetch_pkg::reset_pc;
        fetch_pc = fetch_pkg::reset_pc;
        ds_pending = 1'b0;
        branch_pc = '0;
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (fifo_rst) begin
                check("reset_imem_req", 32'd0, 32'(imem_req));
                check("reset_issue_valid1", 32'd0, 32'(issue_valid1));
                check("reset_issue_valid2", 32'd0, 32'(issue_valid2));
                check("reset_delay_slot", 32'd0, 32'(issue_delay_slot));
                check("reset_empty", 32'd1, 32'(empty));
                check("reset_full", 32'd0, 32'(full));
            end else begin
                if (decode_stall) begin
                    check("stall_holds_issue", 32'd0, 32'(issue_valid1));
                end
                if (full) begin
                    full_seen++;
                    check("full_stops_fetch", 32'd0, 32'(imem_req));
                end
                // fetch asks for aligned pairs in order
                if (imem_req) begin
                    check("fetch_addr", fetch_pc, imem_addr);
                    fetch_pc = fetch_pc + 32'd8;
                end
                if (empty) begin
                    check("empty_no_issue", 32'd0, 32'(issue_valid1));
                end
                if (issue_valid1) begin
                    check("pc_slot1", expected_pc, issue_pc1);
                    check("inst_slot1", mem_word(expected_pc), issue_inst1);
                    check("exp_slot1", 32'(mem_exp(expected_pc)), 32'(issue_exp1));
                    check("delay_slot_flag", 32'(ds_pending), 32'(issue_delay_slot));
                    if (ds_pending) begin
                        check("delay_slot_pc", branch_pc + 32'd4, issue_pc1);
                        delay_slots++;
                    end
                    // a second entry held shows as the next address in slot 2
                    if (issue_pc2 == issue_pc1 + 32'd4) begin
                        check("pairing", 32'(pair_ok(issue_inst1, issue_inst2)),
                              32'(issue_valid2));
                    end else begin
                        check("lone_entry_single", 32'd0, 32'(issue_valid2));
                    end
                    ds_pending = is_branch_word(issue_inst1) && !issue_valid2;
                    branch_pc = issue_pc1;
                    expected_pc = expected_pc + 32'd4;
                    issued++;
                    if (issue_valid2) begin
                        check("pc_slot2", expected_pc, issue_pc2);
                        check("inst_slot2", mem_word(expected_pc), issue_inst2);
                        check("exp_slot2", 32'(mem_exp(expected_pc)), 32'(issue_exp2));
                        expected_pc = expected_pc + 32'd4;
                        issued++;
                    end
                end else begin
                    check("idle_slot2", 32'd0, 32'(issue_valid2));
                    check("idle_delay_slot", 32'd0, 32'(issue_delay_slot));
                end
                // flush drops the old stream and the pending marker
                if (redirect) begin
                    check("redirect_no_req", 32'd0, 32'(imem_req));
                    expected_pc = redirect_pc;
                    fetch_pc = redirect_pc;
                    ds_pending = 1'b0;
                    redirects++;
                end
            end
        end
    end

    // stimulus
    initial begin
        logic [31:0] r;
        int          stall_left;
        int          cyc;
        fifo_rst = 1'b1;
        redirect = 1'b0;
        redirect_pc = '0;
        decode_stall = 1'b0;
        lfsr_state = lfsr_seed;
        stall_left = 0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        fifo_rst = 1'b0;
        for (cyc = 0; cyc < test_cycles; cyc++) begin
            @(posedge clk);
            #2;
            if (cyc >= calm_cycles) begin
                rand_bits(4, r);
                if (stall_left > 0) begin
                    decode_stall = 1'b1;
                    stall_left--;
                end else if (r[3:0] == 4'd0) begin
                    // long stall, lets the queue fill up
                    decode_stall = 1'b1;
                    stall_left = 14;
                end else begin
                    decode_stall = r[3:0] < 4'd4;
                end
                rand_bits(6, r);
                redirect = r[5:0] == 6'd0;
                if (redirect) begin
                    rand_bits(12, r);
                    redirect_pc = 32'h0040_0000 | {17'd0, r[11:0], 3'd0};
                end
            end
        end
        @(posedge clk);
        #2;
        redirect = 1'b0;
        decode_stall = 1'b0;
        repeat (4) @(posedge clk);
        check("enough_issued", 32'd1, 32'(issued > 1000));
        check("redirects_seen", 32'd1, 32'(redirects > 0));
        check("delay_slots_seen", 32'd1, 32'(delay_slots > 0));
        check("full_reached", 32'd1, 32'(full_seen > 0));
        $display("TEST OK");
        $finish;
    end

    // hard stop if the run goes on past its length
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout, the test did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

endmodule

//--- fetch_frontend.f
design/fetch_pkg.sv
design/mips_inst_pkg.sv
design/fetch_pc_gen.sv
design/inst_fifo.sv
design/dual_issue_ctrl.sv
design/fetch_top.sv
test/fetch_assertions.sv
test/fetch_tb.sv

//--- Makefile
# Verilator build and run of the fetch front end

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= fetch_frontend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^TEST OK$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
